/* vlog.f */
design/mod_arith_pkg.sv
design/if_axi_stream.sv
design/mod_add_pipe.sv
design/mod_sub_pipe.sv
design/op_dispatch.sv
design/result_arb.sv
design/mod_arith_top.sv
dv/mod_arith_sva.sv
dv/tb_mod_arith.sv

/* Makefile */
# Verilator build and run of tb_mod_arith.

SIM := obj_dir/Vtb_mod_arith

.PHONY: all run clean

all: run

$(SIM): vlog.f $(shell grep -v '^+' vlog.f)
	verilator --binary --timing --assert --top-module tb_mod_arith -f vlog.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* dv/tb_mod_arith.sv */
// tb_mod_arith
// testbench for the modular add/sub unit. random operands from an lcg,
// a tag-indexed reference model and scoreboard, latency and throughput
// checks, and random output back-pressure.

`timescale 1ns/100ps

module tb_mod_arith
  import mod_arith_pkg::*;
();

  localparam int              BITS    = DEF_BITS;
  localparam logic [BITS-1:0] P       = DEF_P;
  localparam int              LEVEL   = DEF_LEVEL;
  localparam int              N_OPS   = 600;
  localparam int              MAX_OUT = 64;             // keeps tags unique in flight.
  localparam int              LIMIT   = 4 * N_OPS + 200;

  logic                    i_clk = 1'b0;
  logic                    i_rst;
  logic                    i_val, o_rdy, o_val, i_rdy;
  logic [BITS-1:0]         i_a, i_b, o_res;
  op_e                     i_op;
  logic [DEF_TAG_BITS-1:0] i_tag, o_tag, tag_next;

  logic [63:0]     seed;
  logic [BITS-1:0] expect_q [256];  // expected result per tag.
  bit              pending  [256];
  int              in_cyc   [256];  // cycle of the input transfer.
  int              cyc = 0;
  int              n_in = 0, n_out = 0, checks = 0;
  int              val_errs = 0, other_errs = 0;
  int              tp_outs = 0, last_out = 0;
  bit              lat_on = 0, tp_on = 0, rand_rdy = 0;

  mod_arith_top i_dut (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_val (i_val), .o_rdy (o_rdy), .i_a (i_a), .i_b (i_b), .i_op (i_op), .i_tag (i_tag),
    .o_val (o_val), .i_rdy (i_rdy), .o_res (o_res), .o_tag (o_tag)
  );

  always #10 i_clk = ~i_clk;  // 20 ns period.

  // 64-bit lcg, the upper bits are the useful ones.
  function automatic logic [63:0] lcg();
    seed = seed * 64'd6364136223846793005 + 64'd1442695040888963407;
    return seed;
  endfunction

  function automatic int unsigned rand_below(int unsigned n);
    logic [63:0] r;
    r = lcg();
    return int'((r >> 32) % 64'(n));
  endfunction

  // kind 0 uniform below p, 1 just under p, else small values from 0.
  function automatic logic [BITS-1:0] rand_operand(int unsigned kind);
    logic [63:0]     r;
    logic [BITS-1:0] v;
    r = lcg();
    case (kind)
      0: begin
        v = r[63 -: BITS];
        if (v >= P) v = v - P;  // only p itself lands here.
      end
      1:       v = P - BITS'(1) - BITS'(r[63:60]);
      default: v = BITS'(r[63:60]);
    endcase
    return v;
  endfunction

  // reference arithmetic straight from the field rules, one bit wider.
  function automatic logic [BITS-1:0] model_result(op_e op, logic [BITS-1:0] a, b);
    logic [BITS:0] t;
    if (op == OP_ADD) t = {1'b0, a} + {1'b0, b};
    else t = {1'b0, a} + {1'b0, P} - {1'b0, b};
    if (t >= {1'b0, P}) t = t - {1'b0, P};
    return t[BITS-1:0];
  endfunction

  task automatic make_pair(output logic [BITS-1:0] a, output logic [BITS-1:0] b);
    case (rand_below(8))
      3: begin  // both ends of the field.
        a = '0;
        b = P - BITS'(1);
      end
      4, 5: begin  // wraps past p.
        a = rand_operand(1);
        b = rand_operand(1);
      end
      6: begin  // a < b.
        a = rand_operand(2);
        b = rand_operand(1);
      end
      7: begin
        a = rand_operand(0);
        b = a;
      end
      default: begin
        a = rand_operand(0);
        b = rand_operand(0);
      end
    endcase
  endtask

  // one cycle, inputs change on the falling edge.
  task automatic tick();
    @(negedge i_clk);
    if (rand_rdy) i_rdy = (rand_below(10) < 6);  // about 60 percent.
  endtask

  task automatic send_op(input op_e op, input logic [BITS-1:0] a, input logic [BITS-1:0] b);
    int base;
    while (n_in - n_out >= MAX_OUT) tick();
    base  = n_in;
    i_val = 1'b1;
    i_op  = op;
    i_a   = a;
    i_b   = b;
    i_tag = tag_next;
    tick();
    while (n_in == base) tick();  // hold until the monitor saw the transfer.
    tag_next = tag_next + 8'd1;
    i_val = 1'b0;
  endtask

  task automatic drain();
    while (n_out != n_in) tick();
  endtask

  task report_and_stop();
    $display("checks %0d, value errors %0d, other errors %0d", checks, val_errs, other_errs);
    if (val_errs + other_errs == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  endtask

  // scoreboard, sampled on the rising edge before the dut registers update.
  always @(posedge i_clk) begin
    cyc = cyc + 1;
    if (!i_rst) begin
      if (tp_on && i_val && !o_rdy) begin
        other_errs++;
        $display("o_rdy dropped at %0t while only adds were sent", $time);
      end
      if (i_val && o_rdy) begin
        if (pending[i_tag]) begin
          other_errs++;
          $display("tag %0d accepted again while still in flight", i_tag);
        end
        expect_q[i_tag] = model_result(i_op, i_a, i_b);
        pending[i_tag]  = 1'b1;
        in_cyc[i_tag]   = cyc;
        n_in++;
      end
      if (o_val && i_rdy) begin
        n_out++;
        if (!pending[o_tag]) begin
          other_errs++;
          $display("result with tag %0d arrived at %0t with nothing pending", o_tag, $time);
        end else begin
          pending[o_tag] = 1'b0;
          checks++;
          if (o_res !== expect_q[o_tag]) begin
            val_errs++;
            $display("** Error at %0t: o_res tag %0d expected %h actual %h",
                     $time, o_tag, expect_q[o_tag], o_res);
          end
          if (lat_on && (cyc - in_cyc[o_tag] != LEVEL + 1)) begin
            other_errs++;
            $display("latency of tag %0d was %0d cycles, not %0d",
                     o_tag, cyc - in_cyc[o_tag], LEVEL + 1);
          end
        end
        if (tp_on) begin
          if (tp_outs > 0 && cyc != last_out + 1) begin
            other_errs++;
            $display("gap in the output stream before %0t", $time);
          end
          tp_outs++;
          last_out = cyc;
        end
      end
    end
  end

  initial begin
    while (cyc < LIMIT) @(posedge i_clk);
    other_errs++;
    $display("timeout after %0d cycles, %0d results still missing", LIMIT, n_in - n_out);
    report_and_stop();
  end

  initial begin
    logic [BITS-1:0] a, b;
    seed     = 64'd44;
    i_rst    = 1'b1;
    i_val    = 1'b0;
    i_rdy    = 1'b1;
    i_a      = '0;
    i_b      = '0;
    i_op     = OP_ADD;
    i_tag    = '0;
    tag_next = '0;
    repeat (3) begin
      @(negedge i_clk);
      if (o_val !== 1'b0) begin
        other_errs++;
        $display("o_val not low during reset at %0t", $time);
      end
    end
    i_rst = 1'b0;
    tick();
    if (o_val !== 1'b0) begin
      other_errs++;
      $display("o_val high in the first cycle after reset");
    end
    if (o_rdy !== 1'b1) begin
      other_errs++;
      $display("o_rdy not high after reset release");
    end
    // idle latency, one op of each kind into an empty unit.
    lat_on = 1'b1;
    make_pair(a, b);
    send_op(OP_ADD, a, b);
    drain();
    make_pair(a, b);
    send_op(OP_SUB, a, b);
    drain();
    lat_on = 1'b0;
    // back-to-back adds with the output always ready.
    tp_on = 1'b1;
    repeat (100) begin
      make_pair(a, b);
      send_op(OP_ADD, a, b);
    end
    drain();
    tp_on = 1'b0;
    // mixed ops under random back-pressure.
    rand_rdy = 1'b1;
    repeat (N_OPS - 102) begin
      make_pair(a, b);
      send_op((rand_below(2) == 0) ? OP_ADD : OP_SUB, a, b);
    end
    rand_rdy = 1'b0;
    i_rdy    = 1'b1;
    drain();
    for (int t = 0; t < 256; t++) begin
      if (pending[t]) begin
        other_errs++;
        $display("tag %0d never returned a result", t);
      end
    end
    report_and_stop();
  end

endmodule

/* dv/mod_arith_sva.sv */
// mod_arith_sva
// protocol checks on the output port of the modular add/sub unit,
// bound into the top level.

`timescale 1ns/100ps

module mod_arith_sva
  import mod_arith_pkg::*;
#(
  parameter int              BITS     = DEF_BITS,
  parameter logic [BITS-1:0] P        = DEF_P,
  parameter int              TAG_BITS = DEF_TAG_BITS
) (
  input logic                i_clk,
  input logic                i_rst,
  input logic                o_val,
  input logic                i_rdy,
  input logic [BITS-1:0]     o_res,
  input logic [TAG_BITS-1:0] o_tag
);

  // output register comes out of reset empty.
  a_idle_after_rst: assert property (@(posedge i_clk) i_rst |=> !o_val)
    else $error("o_val high in the first cycle after reset");

  // a stalled result holds until the sink takes it.
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_res) && $stable(o_tag))
    else $error("output changed while stalled");

  a_range: assert property (@(posedge i_clk) disable iff (i_rst) o_val |-> o_res < P)
    else $error("o_res not reduced below the modulus");  // results stay in the field.

endmodule

bind mod_arith_top mod_arith_sva #(.BITS(BITS), .P(P), .TAG_BITS(TAG_BITS)) u_sva (
  .i_clk (i_clk),
  .i_rst (i_rst),
  .o_val (o_val),
  .i_rdy (i_rdy),
  .o_res (o_res),
  .o_tag (o_tag)
);

/* design/mod_arith_top.sv */
// mod_arith_top
// pipelined modular add/sub unit for a prime-field datapath.
// one op per cycle in, results out with a tag, possibly reordered.
// dispatch -> add or sub pipe -> round-robin output register.

`timescale 1ns/100ps

module mod_arith_top
  import mod_arith_pkg::*;
#(
  parameter int              BITS     = DEF_BITS,
  parameter logic [BITS-1:0] P        = DEF_P,
  parameter int              LEVEL    = DEF_LEVEL,
  parameter int              TAG_BITS = DEF_TAG_BITS
) (
  input  logic                i_clk,
  input  logic                i_rst,
  // operation input.
  input  logic                i_val,
  output logic                o_rdy,
  input  logic [BITS-1:0]     i_a,
  input  logic [BITS-1:0]     i_b,
  input  op_e                 i_op,
  input  logic [TAG_BITS-1:0] i_tag,
  // result output.
  output logic                o_val,
  input  logic                i_rdy,
  output logic [BITS-1:0]     o_res,
  output logic [TAG_BITS-1:0] o_tag
);

  // operand streams carry b:a, result streams carry 0:res.
  if_axi_stream #(.DAT_BITS(2*BITS), .CTL_BITS(TAG_BITS)) add_in  ();
  if_axi_stream #(.DAT_BITS(2*BITS), .CTL_BITS(TAG_BITS)) sub_in  ();
  if_axi_stream #(.DAT_BITS(2*BITS), .CTL_BITS(TAG_BITS)) add_out ();
  if_axi_stream #(.DAT_BITS(2*BITS), .CTL_BITS(TAG_BITS)) sub_out ();

  op_dispatch #(.BITS(BITS), .TAG_BITS(TAG_BITS)) u_dispatch (
    .i_val (i_val),
    .o_rdy (o_rdy),
    .i_a   (i_a),
    .i_b   (i_b),
    .i_op  (i_op),
    .i_tag (i_tag),
    .o_add (add_in),
    .o_sub (sub_in)
  );

  mod_add_pipe #(.BITS(BITS), .P(P), .LEVEL(LEVEL), .TAG_BITS(TAG_BITS)) u_add (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_add (add_in),
    .o_add (add_out)
  );

  mod_sub_pipe #(.BITS(BITS), .P(P), .LEVEL(LEVEL), .TAG_BITS(TAG_BITS)) u_sub (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_sub (sub_in),
    .o_sub (sub_out)
  );

  result_arb #(.BITS(BITS), .TAG_BITS(TAG_BITS)) u_arb (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_add (add_out),
    .i_sub (sub_out),
    .o_val (o_val),
    .i_rdy (i_rdy),
    .o_res (o_res),
    .o_tag (o_tag)
  );

endmodule

/* design/result_arb.sv */
// result_arb
// round-robin merge of the adder and subtractor result streams
// into a single registered output with valid/ready.

`timescale 1ns/100ps

module result_arb
  import mod_arith_pkg::*;
#(
  parameter int BITS     = DEF_BITS,
  parameter int TAG_BITS = DEF_TAG_BITS
) (
  input  logic                i_clk,
  input  logic                i_rst,
  if_axi_stream.sink          i_add,
  if_axi_stream.sink          i_sub,
  output logic                o_val,
  input  logic                i_rdy,
  output logic [BITS-1:0]     o_res,
  output logic [TAG_BITS-1:0] o_tag
);

  logic load;      // output register free this cycle.
  logic prio_sub;  // 1 when the subtractor wins a tie.
  logic take_add;
  logic take_sub;

  assign load = ~o_val | i_rdy;

  // on a tie, the one that lost last time goes first.
  assign i_add.rdy = load & (~i_sub.val | ~prio_sub);
  assign i_sub.rdy = load & (~i_add.val | prio_sub);

  assign take_add = i_add.val & i_add.rdy;
  assign take_sub = i_sub.val & i_sub.rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val    <= 1'b0;
      prio_sub <= 1'b0;
    end else begin
      if (load) o_val <= take_add | take_sub;  // drain or refill.
      if (take_add) prio_sub <= 1'b1;          // hand the tie to the other side.
      else if (take_sub) prio_sub <= 1'b0;
    end
  end

  // payload only, val qualifies it.
  always_ff @(posedge i_clk) begin
    if (take_add) begin
      o_res <= i_add.dat[BITS-1:0];
      o_tag <= i_add.ctl;
    end else if (take_sub) begin
      o_res <= i_sub.dat[BITS-1:0];
      o_tag <= i_sub.ctl;
    end
  end

endmodule

/* design/op_dispatch.sv */
// op_dispatch
// steers each input operation to the adder or the subtractor stream.
// purely combinational, a stalled pipe only holds back its own kind.

`timescale 1ns/100ps

module op_dispatch
  import mod_arith_pkg::*;
#(
  parameter int BITS     = DEF_BITS,
  parameter int TAG_BITS = DEF_TAG_BITS
) (
  input  logic                i_val,
  output logic                o_rdy,
  input  logic [BITS-1:0]     i_a,
  input  logic [BITS-1:0]     i_b,
  input  op_e                 i_op,
  input  logic [TAG_BITS-1:0] i_tag,
  if_axi_stream.source        o_add,
  if_axi_stream.source        o_sub
);

  logic is_add;

  assign is_add = (i_op == OP_ADD);

  // both streams see the same packed beat, only one gets val.
  assign o_add.dat = {i_b, i_a};  // b upper, a lower.
  assign o_add.ctl = i_tag;
  assign o_sub.dat = {i_b, i_a};
  assign o_sub.ctl = i_tag;

  assign o_add.val = i_val & is_add;
  assign o_sub.val = i_val & ~is_add;

  // ready of whichever pipe the op is headed for.
  assign o_rdy = is_add ? o_add.rdy : o_sub.rdy;

endmodule

/* design/mod_sub_pipe.sv */
// mod_sub_pipe
// pipelined modular subtractor, mirror of the adder pipe.
// a plain difference and a difference-plus-p advance one chunk per stage,
// the final borrow picks which one leaves. result is (a - b) mod p.

`timescale 1ns/100ps

module mod_sub_pipe
  import mod_arith_pkg::*;
#(
  parameter int              BITS     = DEF_BITS,
  parameter logic [BITS-1:0] P        = DEF_P,
  parameter int              LEVEL    = DEF_LEVEL,
  parameter int              TAG_BITS = DEF_TAG_BITS
) (
  input  logic         i_clk,
  input  logic         i_rst,
  if_axi_stream.sink   i_sub,
  if_axi_stream.source o_sub
);

  localparam int PAD_BITS = ((BITS + LEVEL - 1) / LEVEL) * LEVEL;
  localparam int CH_BITS  = PAD_BITS / LEVEL;
  localparam logic [PAD_BITS-1:0] P_PAD = PAD_BITS'(P);

  logic                val_q [LEVEL+1];
  logic                rdy   [LEVEL+1];
  logic [TAG_BITS-1:0] ctl_q [LEVEL+1];
  logic [PAD_BITS-1:0] a_q   [LEVEL];
  logic [PAD_BITS-1:0] b_q   [LEVEL];
  logic [PAD_BITS-1:0] dif_q [LEVEL+1];  // a - b mod 2^pad.
  logic [PAD_BITS-1:0] adj_q [LEVEL+1];  // a - b + p.
  logic                bw_q  [LEVEL+1];  // borrow of a - b, last one decides.
  logic                cy_q  [LEVEL];    // carry of the plus-p chain, top one dropped.

  assign val_q[0] = i_sub.val;
  assign ctl_q[0] = i_sub.ctl;
  assign a_q[0]   = PAD_BITS'(i_sub.dat[0 +: BITS]);
  assign b_q[0]   = PAD_BITS'(i_sub.dat[BITS +: BITS]);
  assign dif_q[0] = '0;
  assign adj_q[0] = '0;
  assign bw_q[0]  = 1'b0;
  assign cy_q[0]  = 1'b0;

  assign rdy[LEVEL] = o_sub.rdy;
  assign i_sub.rdy  = rdy[0];

  for (genvar g = 0; g < LEVEL; g++) begin : g_stage
    logic [CH_BITS:0]    dif_c;  // top bit is the borrow out.
    logic [CH_BITS:0]    adj_c;  // top bit is the carry out.
    logic [PAD_BITS-1:0] dif_d;
    logic [PAD_BITS-1:0] adj_d;

    assign rdy[g] = ~val_q[g+1] | rdy[g+1];

    always_comb begin
      dif_c = {1'b0, a_q[g][g*CH_BITS +: CH_BITS]} -
              {1'b0, b_q[g][g*CH_BITS +: CH_BITS]} -
              (CH_BITS+1)'(bw_q[g]);
      adj_c = {1'b0, dif_c[CH_BITS-1:0]} +
              {1'b0, P_PAD[g*CH_BITS +: CH_BITS]} +
              (CH_BITS+1)'(cy_q[g]);
      dif_d = dif_q[g];
      dif_d[g*CH_BITS +: CH_BITS] = dif_c[CH_BITS-1:0];
      adj_d = adj_q[g];
      adj_d[g*CH_BITS +: CH_BITS] = adj_c[CH_BITS-1:0];
    end

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        val_q[g+1] <= 1'b0;
      end else if (rdy[g]) begin
        val_q[g+1] <= val_q[g];
      end
    end

    always_ff @(posedge i_clk) begin
      if (rdy[g]) begin
        ctl_q[g+1] <= ctl_q[g];
        dif_q[g+1] <= dif_d;
        adj_q[g+1] <= adj_d;
        bw_q[g+1]  <= dif_c[CH_BITS];
      end
    end

    if (g < LEVEL - 1) begin : g_fwd
      always_ff @(posedge i_clk) begin
        if (rdy[g]) begin
          a_q[g+1]  <= a_q[g];
          b_q[g+1]  <= b_q[g];
          cy_q[g+1] <= adj_c[CH_BITS];
        end
      end
    end
  end

  assign o_sub.val = val_q[LEVEL];
  assign o_sub.ctl = ctl_q[LEVEL];
  // a borrow out means a < b, so p is added back.
  assign o_sub.dat = {{BITS{1'b0}},
                      bw_q[LEVEL] ? adj_q[LEVEL][BITS-1:0] : dif_q[LEVEL][BITS-1:0]};

endmodule

/* design/mod_add_pipe.sv */
// mod_add_pipe
// pipelined modular adder, one chunk of the operands per stage.
// each stage extends a plain sum and a sum-minus-p in parallel, the
// last one picks the reduced value. result is (a + b) mod p.

`timescale 1ns/100ps

module mod_add_pipe
  import mod_arith_pkg::*;
#(
  parameter int              BITS     = DEF_BITS,
  parameter logic [BITS-1:0] P        = DEF_P,
  parameter int              LEVEL    = DEF_LEVEL,
  parameter int              TAG_BITS = DEF_TAG_BITS
) (
  input  logic         i_clk,
  input  logic         i_rst,
  if_axi_stream.sink   i_add,
  if_axi_stream.source o_add
);

  // width rounded up so every stage gets an equal chunk.
  localparam int PAD_BITS = ((BITS + LEVEL - 1) / LEVEL) * LEVEL;
  localparam int CH_BITS  = PAD_BITS / LEVEL;
  localparam logic [PAD_BITS-1:0] P_PAD = PAD_BITS'(P);

  logic                val_q [LEVEL+1];  // index 0 is the input port.
  logic                rdy   [LEVEL+1];
  logic [TAG_BITS-1:0] ctl_q [LEVEL+1];
  logic [PAD_BITS-1:0] a_q   [LEVEL];    // operands only needed up to the last stage.
  logic [PAD_BITS-1:0] b_q   [LEVEL];
  logic [PAD_BITS-1:0] sum_q [LEVEL+1];  // plain sum, filled chunk by chunk.
  logic [PAD_BITS-1:0] red_q [LEVEL+1];  // sum - p, filled chunk by chunk.
  logic                cy_q  [LEVEL+1];  // carry of the plain chain.
  logic                bw_q  [LEVEL+1];  // borrow of the minus-p chain.
  logic                fin_bw;

  assign val_q[0] = i_add.val;
  assign ctl_q[0] = i_add.ctl;
  assign a_q[0]   = PAD_BITS'(i_add.dat[0 +: BITS]);     // a in the lower half.
  assign b_q[0]   = PAD_BITS'(i_add.dat[BITS +: BITS]);  // b in the upper half.
  assign sum_q[0] = '0;
  assign red_q[0] = '0;
  assign cy_q[0]  = 1'b0;
  assign bw_q[0]  = 1'b0;

  assign rdy[LEVEL] = o_add.rdy;
  assign i_add.rdy  = rdy[0];  // combinational ready chain.

  for (genvar g = 0; g < LEVEL; g++) begin : g_stage
    logic [CH_BITS:0]    add_c;  // chunk sum, top bit is the carry.
    logic [CH_BITS:0]    sub_c;  // chunk sum - p chunk, top bit is the borrow.
    logic [PAD_BITS-1:0] sum_d;
    logic [PAD_BITS-1:0] red_d;

    // stage loads when empty or when its contents move on.
    assign rdy[g] = ~val_q[g+1] | rdy[g+1];

    always_comb begin
      add_c = {1'b0, a_q[g][g*CH_BITS +: CH_BITS]} +
              {1'b0, b_q[g][g*CH_BITS +: CH_BITS]} +
              (CH_BITS+1)'(cy_q[g]);
      // subtract p from this chunk of the plain sum.
      sub_c = {1'b0, add_c[CH_BITS-1:0]} -
              {1'b0, P_PAD[g*CH_BITS +: CH_BITS]} -
              (CH_BITS+1)'(bw_q[g]);
      sum_d = sum_q[g];
      sum_d[g*CH_BITS +: CH_BITS] = add_c[CH_BITS-1:0];
      red_d = red_q[g];
      red_d[g*CH_BITS +: CH_BITS] = sub_c[CH_BITS-1:0];
    end

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        val_q[g+1] <= 1'b0;
      end else if (rdy[g]) begin
        val_q[g+1] <= val_q[g];
      end
    end

    always_ff @(posedge i_clk) begin
      if (rdy[g]) begin
        ctl_q[g+1] <= ctl_q[g];
        sum_q[g+1] <= sum_d;
        red_q[g+1] <= red_d;
        cy_q[g+1]  <= add_c[CH_BITS];
        bw_q[g+1]  <= sub_c[CH_BITS];
      end
    end

    // operands travel on only while upper chunks remain.
    if (g < LEVEL - 1) begin : g_fwd
      always_ff @(posedge i_clk) begin
        if (rdy[g]) begin
          a_q[g+1] <= a_q[g];
          b_q[g+1] <= b_q[g];
        end
      end
    end
  end

  // a final carry means the sum is past 2^pad, so it cannot be below p.
  assign fin_bw = bw_q[LEVEL] & ~cy_q[LEVEL];

  assign o_add.val = val_q[LEVEL];
  assign o_add.ctl = ctl_q[LEVEL];
  assign o_add.dat = {{BITS{1'b0}},
                      fin_bw ? sum_q[LEVEL][BITS-1:0] : red_q[LEVEL][BITS-1:0]};

endmodule

/* design/if_axi_stream.sv */
// if_axi_stream
// single-beat valid/ready stream with a data word and a control word.
// a beat moves on a rising edge with val and rdy both high.

`timescale 1ns/100ps

interface if_axi_stream #(
  parameter int DAT_BITS = 128,
  parameter int CTL_BITS = 8
) ();

  logic                val;  // source has a beat.
  logic                rdy;  // sink can take it.
  logic [DAT_BITS-1:0] dat;  // payload.
  logic [CTL_BITS-1:0] ctl;  // side info, the tag here.

  // producer side, holds val/dat/ctl until the transfer edge.
  modport source (
    output val,
    output dat,
    output ctl,
    input  rdy
  );

  // consumer side.
  modport sink (
    input  val,
    input  dat,
    input  ctl,
    output rdy
  );

endinterface

/* design/mod_arith_pkg.sv */
// mod_arith_pkg
// shared types and default constants for the prime-field add/sub unit.
// the default modulus is the mersenne prime 2^61-1.

package mod_arith_pkg;

  // operation select carried with every input beat.
  typedef enum logic {
    OP_ADD = 1'b0,  // (a + b) mod p.
    OP_SUB = 1'b1   // (a - b) mod p.
  } op_e;

  // operand width, equal to the width of the default modulus.
  localparam int DEF_BITS = 61;

  // default modulus, 2^61 - 1.
  localparam logic [DEF_BITS-1:0] DEF_P = 61'h1FFF_FFFF_FFFF_FFFF;

  // pipeline depth; 61 bits over 3 stages needs padding to 63.
  localparam int DEF_LEVEL = 3;

  // tag width, lets the receiver match out-of-order results.
  localparam int DEF_TAG_BITS = 8;

endpackage
